/* alu_pipe.sv */
`timescale 1ns/1ps
`include "iq_defs.svh"

module alu_pipe
    import iq_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset_n,
    // From the queue
    input  logic                  issue_valid,
    input  iq_payload_t           issue_payload,
    output logic                  alu_ready,
    // Register file reads
    output logic [`REG_IDX_W-1:0] rf_addr_a,
    output logic [`REG_IDX_W-1:0] rf_addr_b,
    input  logic [`DATA_W-1:0]    rf_data_a,
    input  logic [`DATA_W-1:0]    rf_data_b,
    // Result port, valid/ready
    output result_t               result,
    output logic                  result_valid,
    input  logic                  result_ready,
    // Writeback and completion
    output logic                  wb_enable,
    output logic [`REG_IDX_W-1:0] done_reg
);

    iq_payload_t        s1_op;
    logic               s1_valid;
    logic               s2_open;
    logic [`DATA_W-1:0] operand_b;
    logic [`DATA_W-1:0] alu_out;

    // Stage 2 empty or draining
    assign s2_open = !result_valid || result_ready;

    // Queue output lags by a cycle, so stage 1 must be certain to be free next cycle
    assign alu_ready = !issue_valid && (!s1_valid || s2_open);

    // ------------------------------------------------------------
    // Stage 1, operand read and execute
    // ------------------------------------------------------------
    assign rf_addr_a = s1_op.rs1;
    assign rf_addr_b = s1_op.rs2;
    assign operand_b = s1_op.use_imm ? s1_op.imm : rf_data_b;

    // Wraps at 16 bits
    always_comb begin
        case (s1_op.op)
            SUB:     alu_out = rf_data_a - operand_b;
            AND:     alu_out = rf_data_a & operand_b;
            XOR:     alu_out = rf_data_a ^ operand_b;
            default: alu_out = rf_data_a + operand_b;
        endcase
    end

    // ------------------------------------------------------------
    // Stage 2, result hold and writeback
    // ------------------------------------------------------------
    assign wb_enable = result_valid && result_ready;
    assign done_reg  = result.rd;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            if (s2_open) begin
                result_valid <= s1_valid;
            end
            if (issue_valid) begin
                s1_valid <= 1'b1;
            end else if (s2_open) begin
                s1_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            s1_op <= issue_payload;
        end
        if (s1_valid && s2_open) begin
            result.seq   <= s1_op.seq;
            result.rd    <= s1_op.rd;
            result.value <= alu_out;
        end
    end

endmodule

/* dispatch_unit.sv */
`timescale 1ns/1ps
`include "iq_defs.svh"

module dispatch_unit
    import iq_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset_n,
    // Four-phase instruction port
    input  logic                  instr_req,
    input  instr_word_u           instr,
    input  logic [`SEQ_W-1:0]     instr_seq,
    output logic                  instr_ack,
    // Queue and tracker status
    input  logic                  queue_full,
    input  logic [`NUM_REGS-1:0]  reader_pending,
    // Completion from the ALU
    input  logic                  done_valid,
    input  logic [`REG_IDX_W-1:0] done_reg,
    // Queue write side
    output logic                  write_enable,
    output iq_payload_t           write_payload,
    output logic                  write_sleep_rs1,
    output logic                  write_sleep_rs2
);

    logic [`NUM_REGS-1:0] busy;
    logic [`NUM_REGS-1:0] busy_now;
    logic                 use_imm;
    logic                 stall;

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------
    assign use_imm = (instr.rr.op == ADDI);

    always_comb begin
        write_payload.op      = instr.rr.op;
        write_payload.rd      = instr.rr.rd;
        write_payload.rs1     = instr.rr.rs1;
        // ri form reads rs1 only; mirrored so the reader mask stays exact
        write_payload.rs2     = use_imm ? instr.ri.rs1 : instr.rr.rs2;
        write_payload.imm     = {{(`DATA_W - 7){instr.ri.imm[6]}}, instr.ri.imm};
        write_payload.use_imm = use_imm;
        write_payload.seq     = instr_seq;
    end

    // ------------------------------------------------------------
    // Scoreboard and hazards
    // ------------------------------------------------------------
    // Register completing this cycle counts as ready
    always_comb begin
        busy_now = busy;
        if (done_valid) begin
            busy_now[done_reg] = 1'b0;
        end
    end

    // RAW goes to sleep bits
    assign write_sleep_rs1 = busy_now[write_payload.rs1];
    assign write_sleep_rs2 = busy_now[write_payload.rs2] && !use_imm;

    // WAW and WAR hold dispatch
    assign stall        = busy_now[write_payload.rd] || reader_pending[write_payload.rd];
    assign write_enable = instr_req && !instr_ack && !stall && !queue_full;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy      <= '0;
            instr_ack <= 1'b0;
        end else begin
            if (done_valid) begin
                busy[done_reg] <= 1'b0;
            end
            // New producer of rd, set wins over a same-cycle clear
            if (write_enable) begin
                busy[write_payload.rd] <= 1'b1;
                instr_ack              <= 1'b1;
            end else if (!instr_req) begin
                instr_ack <= 1'b0;
            end
        end
    end

endmodule

/* iq_defs.svh */
`ifndef IQ_DEFS_SVH
`define IQ_DEFS_SVH

// Issue queue size and entry index width
`define IQ_DEPTH   8
`define IQ_IDX_W   3

// Architectural registers
`define NUM_REGS   8
`define REG_IDX_W  3

// Datapath and sequence tag widths
`define DATA_W     16
`define SEQ_W      4

`endif

/* iq_pkg.sv */
`include "iq_defs.svh"

package iq_pkg;

    // Opcodes, ADDI is the only ri-form op
    typedef enum logic [2:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        AND  = 3'd2,
        XOR  = 3'd3,
        ADDI = 3'd4
    } alu_op_t;

    // Register-register form
    typedef struct packed {
        alu_op_t               op;
        logic [`REG_IDX_W-1:0] rd;
        logic [`REG_IDX_W-1:0] rs1;
        logic [`REG_IDX_W-1:0] rs2;
        logic [3:0]            spare;
    } instr_rr_t;

    // Register-immediate form, 7-bit signed immediate
    typedef struct packed {
        alu_op_t               op;
        logic [`REG_IDX_W-1:0] rd;
        logic [`REG_IDX_W-1:0] rs1;
        logic signed [6:0]     imm;
    } instr_ri_t;

    // One 16-bit instruction word, two views
    typedef union packed {
        instr_rr_t rr;
        instr_ri_t ri;
    } instr_word_u;

    // Decoded entry held in the queue
    typedef struct packed {
        alu_op_t               op;
        logic [`REG_IDX_W-1:0] rd;
        logic [`REG_IDX_W-1:0] rs1;
        logic [`REG_IDX_W-1:0] rs2;
        logic [`DATA_W-1:0]    imm;
        logic                  use_imm;
        logic [`SEQ_W-1:0]     seq;
    } iq_payload_t;

    // Completed result
    typedef struct packed {
        logic [`SEQ_W-1:0]     seq;
        logic [`REG_IDX_W-1:0] rd;
        logic [`DATA_W-1:0]    value;
    } result_t;

    // Index of the lowest set bit, zero when none set
    function automatic logic [`IQ_IDX_W-1:0] lowest_index(input logic [`IQ_DEPTH-1:0] vec);
        logic [`IQ_IDX_W-1:0] idx;
        idx = '0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = `IQ_IDX_W'(i);
            end
        end
        return idx;
    endfunction

endpackage

/* iq_tests.mem */
// Columns: instruction word, seq, expected result value (hex)
// Expected values follow in-order execution from all registers at zero
843F 0 003F
8840 1 FFC0
8C7F 2 FFFF
1130 3 FFBF
34A0 4 007F
5990 5 003F
7CA0 6 FFFF
8601 7 FFC0
2A90 8 00BF
0D20 9 017E
7190 A FEBE
1640 B FD7C
9BFE C FFFD
// back-pressure group
8383 D 0002
2770 E FFFE
0810 F 0000
6F00 0 FFFF
53E0 1 FFFD
9591 2 0010
3AA0 3 0010
1E60 4 000D
6390 5 FFF3
8476 6 FFE9
// register reuse
08D0 7 FFF9
9507 8 0000
2AA0 9 0007

/* issue_queue.sv */
`timescale 1ns/1ps
`include "iq_defs.svh"

module issue_queue
    import iq_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset_n,
    // Write side
    input  iq_payload_t          write_data,
    input  logic                 write_sleep_rs1,
    input  logic                 write_sleep_rs2,
    input  logic                 write_enable,
    output logic                 queue_full,
    output logic [`IQ_IDX_W-1:0] alloc_index,
    // Wake ports, one entry each per cycle
    input  logic [`IQ_IDX_W-1:0] wake_rs1_index,
    input  logic                 wake_rs1_enable,
    input  logic [`IQ_IDX_W-1:0] wake_rs2_index,
    input  logic                 wake_rs2_enable,
    // Issue side, read_enable means the ALU can accept
    input  logic                 read_enable,
    output iq_payload_t          read_data,
    output logic                 read_data_valid,
    output logic [`IQ_IDX_W-1:0] issue_index
);

    iq_payload_t          data_array [`IQ_DEPTH];
    logic [`IQ_DEPTH-1:0] valid_vec;
    logic [`IQ_DEPTH-1:0] sleep_rs1_vec;
    logic [`IQ_DEPTH-1:0] sleep_rs2_vec;
    logic [`IQ_DEPTH-1:0] awake_vec;
    logic [`IQ_IDX_W-1:0] read_index;
    logic                 do_write;
    logic                 do_read;

    // ------------------------------------------------------------
    // Slot selection
    // ------------------------------------------------------------
    // First free slot
    assign alloc_index = lowest_index(~valid_vec);
    assign queue_full  = &valid_vec;
    assign do_write    = write_enable && !queue_full;

    // Lowest valid entry with both sources awake
    assign awake_vec  = valid_vec & ~sleep_rs1_vec & ~sleep_rs2_vec;
    assign read_index = lowest_index(awake_vec);
    assign do_read    = read_enable && (|awake_vec);

    // Entry storage
    always_ff @(posedge clock) begin
        if (do_write) begin
            data_array[alloc_index] <= write_data;
        end
    end

    // Issue output register
    always_ff @(posedge clock) begin
        if (do_read) begin
            read_data   <= data_array[read_index];
            issue_index <= read_index;
        end
    end

    // ------------------------------------------------------------
    // Valid and sleep state
    // ------------------------------------------------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid_vec       <= '0;
            sleep_rs1_vec   <= '0;
            sleep_rs2_vec   <= '0;
            read_data_valid <= 1'b0;
        end else begin
            read_data_valid <= do_read;
            if (do_read) begin
                valid_vec[read_index] <= 1'b0;
            end
            if (do_write) begin
                valid_vec[alloc_index]     <= 1'b1;
                sleep_rs1_vec[alloc_index] <= write_sleep_rs1;
                sleep_rs2_vec[alloc_index] <= write_sleep_rs2;
            end
            // Wake comes last, so it beats a same-cycle write
            if (wake_rs1_enable) begin
                sleep_rs1_vec[wake_rs1_index] <= 1'b0;
            end
            if (wake_rs2_enable) begin
                sleep_rs2_vec[wake_rs2_index] <= 1'b0;
            end
        end
    end

endmodule

/* ooo_issue_top.sv */
`timescale 1ns/1ps
`include "iq_defs.svh"

module ooo_issue_top
    import iq_pkg::*;
(
    input  logic              clock,
    input  logic              reset_n,
    input  logic              instr_req,
    input  instr_word_u       instr,
    input  logic [`SEQ_W-1:0] instr_seq,
    output logic              instr_ack,
    output result_t           result,
    output logic              result_valid,
    input  logic              result_ready
);

    // Dispatch to queue and tracker
    iq_payload_t           write_payload;
    logic                  write_enable;
    logic                  write_sleep_rs1;
    logic                  write_sleep_rs2;
    logic                  queue_full;
    logic [`IQ_IDX_W-1:0]  alloc_index;
    logic [`NUM_REGS-1:0]  reader_pending;
    // Wake path
    logic [`IQ_IDX_W-1:0]  wake_rs1_index;
    logic                  wake_rs1_enable;
    logic [`IQ_IDX_W-1:0]  wake_rs2_index;
    logic                  wake_rs2_enable;
    // Issue path
    iq_payload_t           read_data;
    logic                  read_data_valid;
    logic [`IQ_IDX_W-1:0]  issue_index;
    logic                  alu_ready;
    // Register file and completion
    logic [`REG_IDX_W-1:0] rf_addr_a;
    logic [`REG_IDX_W-1:0] rf_addr_b;
    logic [`DATA_W-1:0]    rf_data_a;
    logic [`DATA_W-1:0]    rf_data_b;
    logic                  done_valid;
    logic [`REG_IDX_W-1:0] done_reg;

    dispatch_unit u_dispatch (
        .clock, .reset_n, .instr_req, .instr, .instr_seq, .instr_ack,
        .queue_full, .reader_pending, .done_valid, .done_reg,
        .write_enable, .write_payload, .write_sleep_rs1, .write_sleep_rs2
    );

    issue_queue u_queue (
        .clock, .reset_n,
        .write_data (write_payload),
        .write_sleep_rs1, .write_sleep_rs2, .write_enable, .queue_full, .alloc_index,
        .wake_rs1_index, .wake_rs1_enable, .wake_rs2_index, .wake_rs2_enable,
        .read_enable (alu_ready),
        .read_data, .read_data_valid, .issue_index
    );

    wakeup_tracker u_tracker (
        .clock, .reset_n,
        .alloc_valid    (write_enable),
        .alloc_index,
        .alloc_rs1      (write_payload.rs1),
        .alloc_rs2      (write_payload.rs2),
        .alloc_wait_rs1 (write_sleep_rs1),
        .alloc_wait_rs2 (write_sleep_rs2),
        .issue_valid    (read_data_valid),
        .issue_index, .done_valid, .done_reg,
        .wake_rs1_index, .wake_rs1_enable, .wake_rs2_index, .wake_rs2_enable,
        .reader_pending
    );

    reg_file u_regs (
        .clock, .reset_n, .rd_addr_a (rf_addr_a), .rd_addr_b (rf_addr_b),
        .rd_data_a (rf_data_a), .rd_data_b (rf_data_b),
        .wr_enable (done_valid), .wr_addr (done_reg), .wr_data (result.value)
    );

    // Writeback strobe doubles as the completion
    alu_pipe u_alu (
        .clock, .reset_n,
        .issue_valid   (read_data_valid),
        .issue_payload (read_data),
        .alu_ready, .rf_addr_a, .rf_addr_b, .rf_data_a, .rf_data_b,
        .result, .result_valid, .result_ready,
        .wb_enable     (done_valid),
        .done_reg
    );

endmodule

/* reg_file.sv */
`timescale 1ns/1ps
`include "iq_defs.svh"

module reg_file (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic [`REG_IDX_W-1:0] rd_addr_a,
    input  logic [`REG_IDX_W-1:0] rd_addr_b,
    output logic [`DATA_W-1:0]    rd_data_a,
    output logic [`DATA_W-1:0]    rd_data_b,
    input  logic                  wr_enable,
    input  logic [`REG_IDX_W-1:0] wr_addr,
    input  logic [`DATA_W-1:0]    wr_data
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    // Asynchronous reads
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    // Registers start at zero
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_enable) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the issue slice testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module tb_ooo_issue -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* sources.f */
+incdir+.
iq_pkg.sv
dispatch_unit.sv
issue_queue.sv
wakeup_tracker.sv
reg_file.sv
alu_pipe.sv
ooo_issue_top.sv
tb_clock_gen.sv
tb_ooo_issue.sv

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset_n
);

    // 100 ns period
    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Reset low for the first 16 rising edges
    initial begin
        reset_n = 1'b0;
        repeat (16) @(posedge clock);
        reset_n <= 1'b1;
    end

endmodule

/* tb_ooo_issue.sv */
`timescale 1ns/1ps
`include "iq_defs.svh"

module tb_ooo_issue
    import iq_pkg::*;
();

    localparam int NUM_TESTS      = 26;
    localparam int TIMEOUT_CYCLES = 40 * NUM_TESTS;
    // First test of the back-pressure group
    localparam int BP_FIRST       = 13;
    // Cycles that result_ready stays low from there
    localparam int BP_HOLD_CYCLES = 30;

    logic              clock;
    logic              reset_n;
    logic              instr_req    = 1'b0;
    instr_word_u       instr        = '0;
    logic [`SEQ_W-1:0] instr_seq    = '0;
    logic              instr_ack;
    result_t           result;
    logic              result_valid;
    logic              result_ready = 1'b0;

    // Instruction word, seq and expected value for each test
    logic [15:0]          test_data [3*NUM_TESTS];
    logic [NUM_TESTS-1:0] sent        = '0;
    logic [NUM_TESTS-1:0] done        = '0;
    int                   cycle_count = 0;
    int                   hold_until  = 0;
    int                   pass_count  = 0;
    int                   fail_count  = 0;
    int                   load_errors = 0;
    int                   reordered   = 0;
    int                   newest_done = -1;
    logic                 stall_seen  = 1'b0;
    result_t              held_result;

    tb_clock_gen clock_gen (
        .clock   (clock),
        .reset_n (reset_n)
    );

    ooo_issue_top UUT (
        .clock, .reset_n, .instr_req, .instr, .instr_seq, .instr_ack,
        .result, .result_valid, .result_ready
    );

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic string test_name(input int idx);
        string group;
        if (idx < 3)
            group = "ri_setup";
        else if (idx < 7)
            group = "rr_basic";
        else if (idx < 11)
            group = "raw_chain";
        else if (idx < BP_FIRST)
            group = "ooo_bypass";
        else if (idx < 23)
            group = "backpressure";
        else
            group = "waw_war";
        return $sformatf("%s_%0d", group, idx);
    endfunction

    // Outstanding test with this seq or -1 if there is none
    function automatic int find_pending(input logic [`SEQ_W-1:0] seq);
        int idx;
        idx = -1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (sent[i] && !done[i] && test_data[3*i+1][`SEQ_W-1:0] == seq) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic print_counts();
        $display("tests %0d, passed %0d, errors %0d, out of order %0d",
                 NUM_TESTS, pass_count, fail_count + load_errors, reordered);
    endtask

    task automatic check_result(input result_t res);
        int          idx;
        instr_word_u word;
        logic [15:0] exp_value;
        idx = find_pending(res.seq);
        assert (idx >= 0) else begin
            $display("ERROR: result seq %0d arrived with no outstanding instruction", res.seq);
            fail_count++;
        end
        if (idx >= 0) begin
            word      = test_data[3*idx];
            exp_value = test_data[3*idx+2];
            done[idx] <= 1'b1;
            // Younger one already back
            if (idx < newest_done)
                reordered++;
            else
                newest_done = idx;
            assert (res.value == exp_value) else begin
                $display("MISMATCH %s value: expected %h, actual %h",
                         test_name(idx), exp_value, res.value);
                fail_count++;
            end
            assert (res.rd == word.rr.rd) else begin
                $display("MISMATCH %s rd: expected r%0d, actual r%0d",
                         test_name(idx), word.rr.rd, res.rd);
                fail_count++;
            end
            if (res.value == exp_value && res.rd == word.rr.rd) begin
                pass_count++;
                $display("ok  %s seq %0d r%0d = %h", test_name(idx), res.seq, res.rd, res.value);
            end
        end
    endtask

    // ------------------------------------------------------------
    // Result side
    // ------------------------------------------------------------
    // result_ready low one cycle in five and through the hold window
    always @(posedge clock) begin
        cycle_count  <= cycle_count + 1;
        result_ready <= (cycle_count >= hold_until) && (cycle_count % 5 != 2);
    end

    always @(posedge clock) begin
        if (reset_n) begin
            // Stalled result must stay put until taken
            if (stall_seen) begin
                assert (result_valid && result == held_result) else begin
                    $display("ERROR: result seq %0d changed or dropped while result_ready was low",
                             held_result.seq);
                    fail_count++;
                end
            end
            if (result_valid && result_ready) begin
                check_result(result);
            end
            stall_seen  <= result_valid && !result_ready;
            held_result <= result;
        end
    end

    // ------------------------------------------------------------
    // Instruction side with the four-phase handshake
    // ------------------------------------------------------------
    initial begin
        $readmemh("iq_tests.mem", test_data);
        assert (!$isunknown(test_data[3*NUM_TESTS-1])) else begin
            $display("ERROR: iq_tests.mem did not provide %0d tests", NUM_TESTS);
            load_errors++;
        end
        wait (reset_n === 1'b1);
        @(posedge clock);
        for (int i = 0; i < NUM_TESTS; i++) begin
            // Reused seq waits for its earlier owner
            while (find_pending(test_data[3*i+1][`SEQ_W-1:0]) >= 0) begin
                @(posedge clock);
            end
            if (i == BP_FIRST) begin
                hold_until <= cycle_count + BP_HOLD_CYCLES;
            end
            instr     <= test_data[3*i];
            instr_seq <= test_data[3*i+1][`SEQ_W-1:0];
            instr_req <= 1'b1;
            sent[i]   <= 1'b1;
            do begin
                @(posedge clock);
            end while (!instr_ack);
            instr_req <= 1'b0;
            do begin
                @(posedge clock);
            end while (instr_ack);
        end
        wait (&done);
        // A few idle cycles to catch duplicate results
        repeat (4) @(posedge clock);
        // Some younger result has to overtake an older sleeping one
        assert (reordered > 0) else begin
            $display("ERROR: no result completed ahead of an older instruction");
            fail_count++;
        end
        print_counts();
        if (fail_count == 0 && load_errors == 0 && pass_count == NUM_TESTS) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Timeout lists what never came back
    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("ERROR: timeout after %0d cycles", cycle_count);
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (!done[i]) begin
                $display("ERROR: %s seq %0d never arrived",
                         test_name(i), test_data[3*i+1][`SEQ_W-1:0]);
            end
        end
        print_counts();
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* wakeup_tracker.sv */
`timescale 1ns/1ps
`include "iq_defs.svh"

module wakeup_tracker
    import iq_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset_n,
    // New queue entry
    input  logic                  alloc_valid,
    input  logic [`IQ_IDX_W-1:0]  alloc_index,
    input  logic [`REG_IDX_W-1:0] alloc_rs1,
    input  logic [`REG_IDX_W-1:0] alloc_rs2,
    input  logic                  alloc_wait_rs1,
    input  logic                  alloc_wait_rs2,
    // Entry leaving the queue
    input  logic                  issue_valid,
    input  logic [`IQ_IDX_W-1:0]  issue_index,
    // Completed register
    input  logic                  done_valid,
    input  logic [`REG_IDX_W-1:0] done_reg,
    // Wake ports into the queue
    output logic [`IQ_IDX_W-1:0]  wake_rs1_index,
    output logic                  wake_rs1_enable,
    output logic [`IQ_IDX_W-1:0]  wake_rs2_index,
    output logic                  wake_rs2_enable,
    // Registers read by unissued entries
    output logic [`NUM_REGS-1:0]  reader_pending
);

    logic [`REG_IDX_W-1:0] tag_rs1 [`IQ_DEPTH];
    logic [`REG_IDX_W-1:0] tag_rs2 [`IQ_DEPTH];
    logic [`IQ_DEPTH-1:0]  live;
    logic [`IQ_DEPTH-1:0]  wait_rs1;
    logic [`IQ_DEPTH-1:0]  wait_rs2;
    logic [`IQ_DEPTH-1:0]  owed_rs1;
    logic [`IQ_DEPTH-1:0]  owed_rs2;
    logic [`IQ_DEPTH-1:0]  hit_rs1;
    logic [`IQ_DEPTH-1:0]  hit_rs2;
    logic [`IQ_DEPTH-1:0]  sent_rs1;
    logic [`IQ_DEPTH-1:0]  sent_rs2;

    // Tag match against this cycle's completion, plus reader mask
    always_comb begin
        reader_pending = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            hit_rs1[i] = done_valid && wait_rs1[i] && (tag_rs1[i] == done_reg);
            hit_rs2[i] = done_valid && wait_rs2[i] && (tag_rs2[i] == done_reg);
            if (live[i]) begin
                reader_pending[tag_rs1[i]] = 1'b1;
                reader_pending[tag_rs2[i]] = 1'b1;
            end
        end
    end

    // Lowest owed bit on each port, isolated
    assign sent_rs1 = owed_rs1 & ~(owed_rs1 - `IQ_DEPTH'(1));
    assign sent_rs2 = owed_rs2 & ~(owed_rs2 - `IQ_DEPTH'(1));

    // Source tags
    always_ff @(posedge clock) begin
        if (alloc_valid) begin
            tag_rs1[alloc_index] <= alloc_rs1;
            tag_rs2[alloc_index] <= alloc_rs2;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            live            <= '0;
            wait_rs1        <= '0;
            wait_rs2        <= '0;
            owed_rs1        <= '0;
            owed_rs2        <= '0;
            wake_rs1_enable <= 1'b0;
            wake_rs2_enable <= 1'b0;
        end else begin
            // Matching waiters become owed, sent ones retire
            wait_rs1 <= wait_rs1 & ~hit_rs1;
            wait_rs2 <= wait_rs2 & ~hit_rs2;
            owed_rs1 <= (owed_rs1 | hit_rs1) & ~sent_rs1;
            owed_rs2 <= (owed_rs2 | hit_rs2) & ~sent_rs2;
            if (issue_valid) begin
                live[issue_index] <= 1'b0;
            end
            // Slot may be reused the cycle its issue is reported
            if (alloc_valid) begin
                live[alloc_index]     <= 1'b1;
                wait_rs1[alloc_index] <= alloc_wait_rs1;
                wait_rs2[alloc_index] <= alloc_wait_rs2;
                owed_rs1[alloc_index] <= 1'b0;
                owed_rs2[alloc_index] <= 1'b0;
            end
            wake_rs1_enable <= |owed_rs1;
            wake_rs2_enable <= |owed_rs2;
        end
    end

    // Wake indexes only matter with their enables
    always_ff @(posedge clock) begin
        wake_rs1_index <= lowest_index(owed_rs1);
        wake_rs2_index <= lowest_index(owed_rs2);
    end

endmodule
